/* rtl/ppu_pkg.sv */
// raster timing, cpu register map, border colour and the rgb565 master palette
`default_nettype none

package ppu_pkg;

    // ----------------------------------------
    // vga raster, 640x480 at 25 mhz
    // ----------------------------------------
    localparam logic [9:0] h_visible = 10'd640;
    localparam logic [9:0] h_front   = 10'd16;
    localparam logic [9:0] h_sync    = 10'd96;
    localparam logic [9:0] h_whole   = 10'd800;

    localparam logic [9:0] v_visible = 10'd480;
    localparam logic [9:0] v_front   = 10'd10;
    localparam logic [9:0] v_sync    = 10'd2;
    localparam logic [9:0] v_whole   = 10'd525;

    // 256 nes dots doubled to 512 columns, centred
    localparam logic [9:0] win_left  = 10'd64;
    localparam logic [9:0] win_right = 10'd576;

    // dot enable on even columns 46..726, 341 dots per line
    // starts 8 dots plus one cycle early so the fetch pipeline is full at win_left
    localparam logic [9:0] dot_first = 10'd46;
    localparam logic [9:0] dot_last  = 10'd726;

    // ppu lines are vga lines divided by two
    localparam logic [8:0] vblank_line = 9'd241;
    localparam logic [8:0] pre_line    = 9'd261;

    // ----------------------------------------
    // cpu register map
    // ----------------------------------------
    localparam logic [15:0] reg_ctrl0  = 16'h2000;
    localparam logic [15:0] reg_ctrl1  = 16'h2001;
    localparam logic [15:0] reg_status = 16'h2002;
    localparam logic [15:0] reg_spradr = 16'h2003;
    localparam logic [15:0] reg_scroll = 16'h2005;
    localparam logic [15:0] reg_addr   = 16'h2006;
    localparam logic [15:0] reg_data   = 16'h2007;

    // 32 palette entries from here
    localparam logic [15:0] pal_base   = 16'h3F00;

    // ----------------------------------------
    // colour
    // ----------------------------------------
    // red in [15:11], green in [10:5], blue in [4:0]
    typedef logic [15:0] rgb565_t;

    // palette ram entry, a master colour number
    typedef logic [5:0] pal_t;

    // dim grey-blue for the side borders
    localparam rgb565_t border_rgb = {5'd3, 6'd3, 5'd3};

    // nes master palette, the unused columns 0x0d-0x0f of each row are black
    localparam rgb565_t master_palette [64] = '{
        16'h73ae, 16'h20d1, 16'h0015, 16'h4013, 16'h880e, 16'ha802, 16'ha000, 16'h7840,
        16'h4160, 16'h0220, 16'h0280, 16'h01e2, 16'h19eb, 16'h0000, 16'h0000, 16'h0000,
        16'hbdf7, 16'h039d, 16'h21dd, 16'h801e, 16'hb817, 16'he00b, 16'hd940, 16'hca61,
        16'h8b80, 16'h04a0, 16'h0540, 16'h0487, 16'h0411, 16'h0000, 16'h0000, 16'h0000,
        16'hffff, 16'h3dff, 16'h5cbf, 16'ha45f, 16'hf3df, 16'hfbb6, 16'hfbac, 16'hfcc7,
        16'hf5e7, 16'h8682, 16'h4ee9, 16'h5fd3, 16'h075b, 16'h0000, 16'h0000, 16'h0000,
        16'hffff, 16'haf3f, 16'hc6bf, 16'hd65f, 16'hfe3f, 16'hfe3b, 16'hfdf6, 16'hfed5,
        16'hff34, 16'he7f4, 16'haf97, 16'hb7f9, 16'h9ffe, 16'h0000, 16'h0000, 16'h0000
    };

endpackage

`default_nettype wire

/* rtl/ppu_ram.sv */
// synchronous ram with a write/read port and a read-only port, generic word type
`timescale 1ns/1ps
`default_nettype none

module ppu_ram #(
    parameter type word_t = logic [7:0],
    parameter int  depth  = 2048
) (
    input  wire logic                     CLK25,
    input  wire logic                     we,
    input  wire logic [$clog2(depth)-1:0] waddr,
    input  wire word_t                    wdata,
    output word_t                         a_rdata,
    input  wire logic [$clog2(depth)-1:0] raddr,
    output word_t                         rdata
);

    word_t mem [depth];

    // port a returns the old word on a write
    always_ff @(posedge CLK25) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        a_rdata <= mem[waddr];
        rdata   <= mem[raddr];
    end

endmodule

`default_nettype wire

/* rtl/vga_timing.sv */
// vga raster counters, sync decode, ppu dot enable, dot position and vblank pulses
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
    input  wire logic       CLK25,
    input  wire logic       rst,
    output logic            hs,
    output logic            vs,
    output logic            visible,
    output logic            in_window,
    output logic            dot_en,
    output logic [8:0]      dot_x,
    output logic [7:0]      dot_y,
    output logic            vblank_set,
    output logic            vblank_clr
);

    logic [9:0] x;
    logic [9:0] y;
    logic       line_end;
    logic       line_start;
    logic [8:0] ppu_line;

    assign line_end   = (x == ppu_pkg::h_whole - 10'd1);
    assign line_start = (x == 10'd0);

    // two vga lines per ppu line
    assign ppu_line = y[9:1];
    assign dot_y    = y[8:1];

    always_ff @(posedge CLK25) begin
        if (rst) begin
            x     <= '0;
            y     <= '0;
            dot_x <= '0;
        end else begin
            if (line_end) begin
                x <= '0;
                y <= (y == ppu_pkg::v_whole - 10'd1) ? 10'd0 : y + 10'd1;
            end else begin
                x <= x + 10'd1;
            end
            // dot number restarts every vga line
            if (line_end) begin
                dot_x <= '0;
            end else if (dot_en) begin
                dot_x <= dot_x + 9'd1;
            end
        end
    end

    // active high sync pulses
    assign hs = (x >= ppu_pkg::h_visible + ppu_pkg::h_front) &&
                (x <  ppu_pkg::h_visible + ppu_pkg::h_front + ppu_pkg::h_sync);
    assign vs = (y >= ppu_pkg::v_visible + ppu_pkg::v_front) &&
                (y <  ppu_pkg::v_visible + ppu_pkg::v_front + ppu_pkg::v_sync);

    assign visible   = (x < ppu_pkg::h_visible) && (y < ppu_pkg::v_visible);
    assign in_window = (x >= ppu_pkg::win_left) && (x < ppu_pkg::win_right);

    // half rate dot clock enable
    assign dot_en = (x >= ppu_pkg::dot_first) && (x <= ppu_pkg::dot_last) &&
                    (x[0] == ppu_pkg::dot_first[0]);

    // once per frame, first cycle of the even vga line of that ppu line
    assign vblank_set = line_start && !y[0] && (ppu_line == ppu_pkg::vblank_line);
    assign vblank_clr = line_start && !y[0] && (ppu_line == ppu_pkg::pre_line);

endmodule

`default_nettype wire

/* rtl/ppu_regs.sv */
// cpu register file, vram address and read buffer, memory write routing, vblank flag
`timescale 1ns/1ps
`default_nettype none

module ppu_regs (
    input  wire logic           CLK25,
    input  wire logic           rst,
    input  wire logic [15:0]    ea,
    input  wire logic [7:0]     din,
    input  wire logic           rd,
    input  wire logic           wreq,
    output logic [7:0]          dout,
    input  wire logic           vblank_set,
    input  wire logic           vblank_clr,
    output logic [13:0]         mem_addr,
    output logic [7:0]          mem_wdata,
    output logic                vram_we,
    output logic                chr_we,
    input  wire logic [7:0]     vram_q,
    input  wire logic [7:0]     chr_q,
    output logic                pal_we,
    output logic [4:0]          pal_addr,
    output ppu_pkg::pal_t       pal_wdata,
    input  wire ppu_pkg::pal_t  pal_q,
    output logic                nt_page,
    output logic                bg_table,
    output logic                bg_on
);

    logic [7:0]  ctrl0;
    logic [7:0]  ctrl1;
    logic [7:0]  spradr;
    logic [15:0] scroll;
    logic [13:0] vaddr;
    logic [7:0]  rbuf;
    logic        vblank;
    logic        pal_rd_q;
    logic        data_wr;
    logic        data_rd;
    logic        status_rd;
    logic        pal_hit;
    logic        to_vram;

    // ----------------------------------------
    // decode
    // ----------------------------------------
    assign data_wr   = wreq && (ea == ppu_pkg::reg_data);
    assign data_rd   = rd && (ea == ppu_pkg::reg_data);
    assign status_rd = rd && (ea == ppu_pkg::reg_status);
    assign pal_hit   = (ea[15:5] == ppu_pkg::pal_base[15:5]);

    // 0x2000 and up is name table space, below is chr
    assign to_vram = (vaddr >= 14'h2000);

    // shared memory port follows the vram address
    assign mem_addr  = vaddr;
    assign mem_wdata = din;
    assign vram_we   = data_wr && to_vram;
    assign chr_we    = data_wr && !to_vram;

    // palette is addressed straight from the bus
    assign pal_we    = wreq && pal_hit;
    assign pal_addr  = ea[4:0];
    assign pal_wdata = din[5:0];

    // ctrl0 bit 0 page, bit 4 bg pattern table; ctrl1 bit 3 bg enable
    assign nt_page  = ctrl0[0];
    assign bg_table = ctrl0[4];
    assign bg_on    = ctrl1[3];

    // ----------------------------------------
    // registers
    // ----------------------------------------
    always_ff @(posedge CLK25) begin
        if (rst) begin
            ctrl0    <= '0;
            ctrl1    <= '0;
            spradr   <= '0;
            scroll   <= '0;
            vaddr    <= '0;
            rbuf     <= '0;
            dout     <= '0;
            pal_rd_q <= 1'b0;
        end else begin
            if (wreq) begin
                case (ea)
                    ppu_pkg::reg_ctrl0:  ctrl0  <= din;
                    ppu_pkg::reg_ctrl1:  ctrl1  <= din;
                    ppu_pkg::reg_spradr: spradr <= din;
                    // two writes shift through, high byte first
                    ppu_pkg::reg_scroll: scroll <= {scroll[7:0], din};
                    ppu_pkg::reg_addr:   vaddr  <= {vaddr[5:0], din};
                    default: ;
                endcase
            end
            if (status_rd) begin
                dout <= {vblank, 7'b0};
            end
            // buffered read, old buffer out and refill from the current address
            if (data_rd) begin
                dout <= rbuf;
                rbuf <= to_vram ? vram_q : chr_q;
            end
            // +1 across, +32 down
            if (data_rd || data_wr) begin
                vaddr <= vaddr + (ctrl0[2] ? 14'd32 : 14'd1);
            end
            // palette ram answers a cycle after the strobe
            pal_rd_q <= rd && pal_hit;
            if (pal_rd_q) begin
                dout <= {2'b00, pal_q};
            end
        end
    end

    // vblank flag, frame start wins over a status read in the same cycle
    always_ff @(posedge CLK25) begin
        if (rst) begin
            vblank <= 1'b0;
        end else if (vblank_set) begin
            vblank <= 1'b1;
        end else if (vblank_clr || status_rd) begin
            vblank <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* rtl/bg_fetch.sv */
// background tile fetcher, name/attribute/pattern reads and per-dot palette index
`timescale 1ns/1ps
`default_nettype none

module bg_fetch (
    input  wire logic       CLK25,
    input  wire logic       rst,
    input  wire logic       dot_en,
    input  wire logic [8:0] dot_x,
    input  wire logic [7:0] dot_y,
    input  wire logic       nt_page,
    input  wire logic       bg_table,
    input  wire logic       bg_on,
    output logic [10:0]     vram_addr,
    output logic [12:0]     chr_addr,
    input  wire logic [7:0] vram_q,
    input  wire logic [7:0] chr_q,
    output logic [3:0]      pix_index
);

    logic [2:0] phase;
    logic [7:0] plane_lo;
    logic [7:0] plane_hi;
    logic [7:0] attr;
    logic [7:0] sh_lo;
    logic [7:0] sh_hi;
    logic [1:0] cur_pal;
    logic [2:0] qsel;

    assign phase = dot_x[2:0];

    // 32x32 pixel quadrant picks two bits of the attribute byte
    assign qsel = {dot_y[4], dot_x[4], 1'b0};

    // ----------------------------------------
    // fetch, one tile per eight dots
    // ----------------------------------------
    always_ff @(posedge CLK25) begin
        if (dot_en) begin
            case (phase)
                // name byte, 32x30 tiles
                3'd0: vram_addr <= {nt_page, dot_y[7:3], dot_x[7:3]};
                // low plane request
                3'd1: chr_addr <= {bg_table, vram_q, 1'b0, dot_y[2:0]};
                3'd2: begin
                    plane_lo  <= chr_q;
                    chr_addr  <= {bg_table, vram_q, 1'b1, dot_y[2:0]};
                    // attribute table sits at offset 0x3c0
                    vram_addr <= {nt_page, 4'b1111, dot_y[7:5], dot_x[7:5]};
                end
                3'd3: begin
                    plane_hi <= chr_q;
                    attr     <= vram_q;
                end
                default: ;
            endcase
            // shifters load at the end of the tile, else move one pixel left
            if (phase == 3'd7) begin
                sh_lo   <= plane_lo;
                sh_hi   <= plane_hi;
                cur_pal <= attr[qsel +: 2];
            end else begin
                sh_lo <= {sh_lo[6:0], 1'b0};
                sh_hi <= {sh_hi[6:0], 1'b0};
            end
        end
    end

    // leftmost pixel first, index zero while background is off
    always_ff @(posedge CLK25) begin
        if (rst) begin
            pix_index <= '0;
        end else if (dot_en) begin
            pix_index <= bg_on ? {cur_pal, sh_hi[7], sh_lo[7]} : 4'd0;
        end
    end

endmodule

`default_nettype wire

/* rtl/video_out.sv */
// palette index mapping, master colour lookup and vga window/border/blank register
`timescale 1ns/1ps
`default_nettype none

module video_out (
    input  wire logic           CLK25,
    input  wire logic           rst,
    input  wire logic           visible,
    input  wire logic           in_window,
    input  wire logic [3:0]     pix_index,
    output logic [4:0]          pal_addr,
    input  wire ppu_pkg::pal_t  pal_q,
    output logic [4:0]          red,
    output logic [5:0]          green,
    output logic [4:0]          blue
);

    ppu_pkg::rgb565_t colour;

    // transparent pixels share the backdrop entry
    assign pal_addr = (pix_index[1:0] == 2'b00) ? 5'd0 : {1'b0, pix_index};

    assign colour = ppu_pkg::master_palette[pal_q];

    // index arrives a cycle early, so pal_q lines up with the current column
    always_ff @(posedge CLK25) begin
        if (rst) begin
            {red, green, blue} <= '0;
        end else if (!visible) begin
            // monitor needs black in blanking
            {red, green, blue} <= '0;
        end else if (in_window) begin
            {red, green, blue} <= colour;
        end else begin
            {red, green, blue} <= ppu_pkg::border_rgb;
        end
    end

endmodule

`default_nettype wire

/* rtl/ppu_top.sv */
// ppu top level, raster, registers, background fetch, video output and the three rams
`timescale 1ns/1ps
`default_nettype none

module ppu_top (
    input  wire logic        CLK25,
    input  wire logic        rst,
    input  wire logic [15:0] ea,
    input  wire logic [7:0]  din,
    input  wire logic        rd,
    input  wire logic        wreq,
    output logic [7:0]       dout,
    output logic [4:0]       red,
    output logic [5:0]       green,
    output logic [4:0]       blue,
    output logic             hs,
    output logic             vs
);

    // raster
    logic          visible;
    logic          in_window;
    logic          dot_en;
    logic [8:0]    dot_x;
    logic [7:0]    dot_y;
    logic          vblank_set;
    logic          vblank_clr;

    // cpu side of the memories
    logic [13:0]   mem_addr;
    logic [7:0]    mem_wdata;
    logic          vram_we;
    logic          chr_we;
    logic [7:0]    vram_q;
    logic [7:0]    chr_q;
    logic          pal_we;
    logic [4:0]    pal_addr_cpu;
    ppu_pkg::pal_t pal_wdata;
    ppu_pkg::pal_t pal_q_cpu;
    logic          nt_page;
    logic          bg_table;
    logic          bg_on;

    // render side
    logic [10:0]   vram_addr;
    logic [12:0]   chr_addr;
    logic [7:0]    vram_bg;
    logic [7:0]    chr_bg;
    logic [3:0]    pix_index;
    logic [4:0]    pal_addr_vid;
    ppu_pkg::pal_t pal_q_vid;

    vga_timing u_timing (
        .CLK25(CLK25), .rst(rst),
        .hs(hs), .vs(vs), .visible(visible), .in_window(in_window),
        .dot_en(dot_en), .dot_x(dot_x), .dot_y(dot_y),
        .vblank_set(vblank_set), .vblank_clr(vblank_clr)
    );

    ppu_regs u_regs (
        .CLK25(CLK25), .rst(rst),
        .ea(ea), .din(din), .rd(rd), .wreq(wreq), .dout(dout),
        .vblank_set(vblank_set), .vblank_clr(vblank_clr),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .vram_we(vram_we), .chr_we(chr_we),
        .vram_q(vram_q), .chr_q(chr_q),
        .pal_we(pal_we), .pal_addr(pal_addr_cpu), .pal_wdata(pal_wdata),
        .pal_q(pal_q_cpu),
        .nt_page(nt_page), .bg_table(bg_table), .bg_on(bg_on)
    );

    bg_fetch u_fetch (
        .CLK25(CLK25), .rst(rst), .dot_en(dot_en),
        .dot_x(dot_x), .dot_y(dot_y),
        .nt_page(nt_page), .bg_table(bg_table), .bg_on(bg_on),
        .vram_addr(vram_addr), .chr_addr(chr_addr),
        .vram_q(vram_bg), .chr_q(chr_bg),
        .pix_index(pix_index)
    );

    video_out u_video (
        .CLK25(CLK25), .rst(rst),
        .visible(visible), .in_window(in_window), .pix_index(pix_index),
        .pal_addr(pal_addr_vid), .pal_q(pal_q_vid),
        .red(red), .green(green), .blue(blue)
    );

    // ----------------------------------------
    // memories
    // ----------------------------------------
    // name tables, 0x2000-0x3fff folded onto 2 kb
    ppu_ram #(.word_t(logic [7:0]), .depth(2048)) u_vram (
        .CLK25(CLK25), .we(vram_we), .waddr(mem_addr[10:0]), .wdata(mem_wdata),
        .a_rdata(vram_q), .raddr(vram_addr), .rdata(vram_bg)
    );

    // pattern tables
    ppu_ram #(.word_t(logic [7:0]), .depth(8192)) u_chr (
        .CLK25(CLK25), .we(chr_we), .waddr(mem_addr[12:0]), .wdata(mem_wdata),
        .a_rdata(chr_q), .raddr(chr_addr), .rdata(chr_bg)
    );

    // 16 background and 16 sprite entries
    ppu_ram #(.word_t(ppu_pkg::pal_t), .depth(32)) u_pal (
        .CLK25(CLK25), .we(pal_we), .waddr(pal_addr_cpu), .wdata(pal_wdata),
        .a_rdata(pal_q_cpu), .raddr(pal_addr_vid), .rdata(pal_q_vid)
    );

endmodule

`default_nettype wire

/* sim/ppu_properties.sv */
// bound assertions on hsync pulse length, cpu strobes and colour during hsync
`timescale 1ns/1ps
`default_nettype none

module ppu_properties (
    input wire logic       CLK25,
    input wire logic       rst,
    input wire logic       hs,
    input wire logic       rd,
    input wire logic       wreq,
    input wire logic [4:0] red,
    input wire logic [5:0] green,
    input wire logic [4:0] blue
);

    int hs_len;
    int hs_fails    = 0;
    int bus_fails   = 0;
    int blank_fails = 0;

    // length of the current hsync pulse
    always_ff @(posedge CLK25) begin
        if (rst || !hs) begin
            hs_len <= 0;
        end else begin
            hs_len <= hs_len + 1;
        end
    end

    hs_width: assert property (@(posedge CLK25) disable iff (rst)
        $fell(hs) |-> hs_len == int'(ppu_pkg::h_sync))
        else begin
            $error("hsync pulse lasted %0d cycles", hs_len);
            hs_fails = hs_fails + 1;
        end

    // the cpu never reads and writes in one cycle
    bus_strobe: assert property (@(posedge CLK25) disable iff (rst) !(rd && wreq))
        else begin
            $error("rd and wreq high together");
            bus_fails = bus_fails + 1;
        end

    hs_black: assert property (@(posedge CLK25) disable iff (rst)
        hs |-> (red == 5'd0) && (green == 6'd0) && (blue == 5'd0))
        else begin
            $error("colour output not black during hsync");
            blank_fails = blank_fails + 1;
        end

endmodule

bind ppu_top ppu_properties u_props (
    .CLK25(CLK25), .rst(rst), .hs(hs), .rd(rd), .wreq(wreq),
    .red(red), .green(green), .blue(blue)
);

`default_nettype wire

/* sim/tb_ppu.sv */
// ppu testbench with clock, reset, watchdog, directed bus and video tests and summary
`timescale 1ns/1ps
`default_nettype none

module tb_ppu;

    localparam int clk_period      = 100;
    localparam int frame_cycles    = int'(ppu_pkg::h_whole) * int'(ppu_pkg::v_whole);
    localparam int watchdog_frames = 12;
    localparam int hs_start        = int'(ppu_pkg::h_visible + ppu_pkg::h_front);
    localparam int vs_start        = int'(ppu_pkg::v_visible + ppu_pkg::v_front);
    localparam int centre_x        = int'(ppu_pkg::h_visible) / 2;
    localparam int centre_y        = int'(ppu_pkg::v_visible) / 2;

    logic        CLK25;
    logic        rst;
    logic [15:0] ea;
    logic [7:0]  din;
    logic        rd;
    logic        wreq;
    logic [7:0]  dout;
    logic [4:0]  red;
    logic [5:0]  green;
    logic [4:0]  blue;
    logic        hs;
    logic        vs;
    logic [15:0] rgb;

    int            errors;
    int            assert_fails;
    ppu_pkg::pal_t pal_model [32];
    logic [7:0]    vram_model [2048];
    logic [7:0]    rbuf_model;
    logic [15:0]   line_rgb [640];

    assign rgb = {red, green, blue};

    ppu_top UUT (
        .CLK25(CLK25), .rst(rst), .ea(ea), .din(din), .rd(rd), .wreq(wreq),
        .dout(dout), .red(red), .green(green), .blue(blue), .hs(hs), .vs(vs)
    );

    initial begin
        CLK25 = 1'b0;
        forever #(clk_period / 2) CLK25 = ~CLK25;
    end

    // the whole run fits in well under twelve frames
    initial begin
        #(watchdog_frames * frame_cycles * clk_period);
        $display("timeout: tests did not finish within %0d frames", watchdog_frames);
        $display("ERRORS FOUND");
        $finish;
    end

    // ----------------------------------------
    // reporting and bus helpers
    // ----------------------------------------
    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Mismatch %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
        errors++;
    endtask

    task automatic report_failure(input string test, input string what);
        $display("%s: %s", test, what);
        errors++;
    endtask

    // one strobe cycle, then idle so accesses stay five cycles apart
    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge CLK25);
        ea   <= addr;
        din  <= data;
        wreq <= 1'b1;
        @(posedge CLK25);
        wreq <= 1'b0;
        repeat (3) @(posedge CLK25);
    endtask

    // palette data lands in dout two edges after the strobe
    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        @(posedge CLK25);
        ea <= addr;
        rd <= 1'b1;
        @(posedge CLK25);
        rd <= 1'b0;
        repeat (2) @(posedge CLK25);
        @(negedge CLK25);
        data = dout;
    endtask

    // returns on the first low half-cycle with vs high, x 0 of line 490
    task automatic wait_vs_rise();
        do begin
            @(negedge CLK25);
        end while (vs);
        do begin
            @(negedge CLK25);
        end while (!vs);
    endtask

    task automatic measure_pulse(input logic use_vs, output int high_len, output int period_len);
        do begin
            @(negedge CLK25);
        end while (use_vs ? vs : hs);
        do begin
            @(negedge CLK25);
        end while (!(use_vs ? vs : hs));
        high_len = 0;
        do begin
            @(negedge CLK25);
            high_len++;
        end while (use_vs ? vs : hs);
        period_len = high_len;
        do begin
            @(negedge CLK25);
            period_len++;
        end while (!(use_vs ? vs : hs));
    endtask

    // colour of column i shows up one cycle later, in column i+1
    task automatic capture_line(input int py);
        wait_vs_rise();
        repeat ((int'(ppu_pkg::v_whole) - vs_start + py) * int'(ppu_pkg::h_whole) + 1)
            @(negedge CLK25);
        line_rgb[0] = rgb;
        for (int i = 1; i < 640; i++) begin
            @(negedge CLK25);
            line_rgb[i] = rgb;
        end
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic reset_state();
        @(negedge CLK25);
        if (rgb !== 16'h0000) report_mismatch("reset_state", 32'h0, 32'(rgb));
        for (int k = 0; k < hs_start; k++) begin
            if (hs !== 1'b0 || vs !== 1'b0) report_failure("reset_state", "sync high too early");
            // blanking columns before the first hsync
            if (k > int'(ppu_pkg::h_visible) && rgb !== 16'h0000)
                report_mismatch("reset_state", 32'h0, 32'(rgb));
            @(negedge CLK25);
        end
        if (hs !== 1'b1) report_failure("reset_state", "hs did not rise at column 656");
    endtask

    task automatic sync_timing();
        int high_len;
        int period_len;
        measure_pulse(1'b0, high_len, period_len);
        if (high_len !== 96) report_mismatch("sync_timing hs width", 96, high_len);
        if (period_len !== 800) report_mismatch("sync_timing line", 800, period_len);
        measure_pulse(1'b1, high_len, period_len);
        if (high_len !== 1600) report_mismatch("sync_timing vs width", 1600, high_len);
        if (period_len !== frame_cycles) begin
            report_mismatch("sync_timing frame", frame_cycles, period_len);
        end
    endtask

    task automatic palette_rw();
        logic [7:0] got;
        for (int i = 0; i < 32; i++) begin
            pal_model[i] = 6'($urandom());
            bus_write(ppu_pkg::pal_base + 16'(i), {2'b00, pal_model[i]});
        end
        for (int i = 0; i < 32; i++) begin
            bus_read(ppu_pkg::pal_base + 16'(i), got);
            if (got !== {2'b00, pal_model[i]}) begin
                report_mismatch("palette_rw", {2'b00, pal_model[i]}, got);
            end
        end
    endtask

    // nine bytes from 0x2400, stepping by stride, kept in the vram model
    task automatic data_port_fill(input logic [7:0] step_bit, input int stride,
                                  input logic [7:0] first);
        bus_write(ppu_pkg::reg_ctrl0, step_bit);
        bus_write(ppu_pkg::reg_addr, 8'h24);
        bus_write(ppu_pkg::reg_addr, 8'h00);
        for (int k = 0; k < 9; k++) begin
            bus_write(ppu_pkg::reg_data, first + 8'(k));
            vram_model['h400 + k * stride] = first + 8'(k);
        end
    endtask

    // nine reads from 0x2400, the first read is the stale buffer
    task automatic data_port_check(input string test, input logic [7:0] step_bit,
                                   input int stride);
        logic [7:0] got;
        logic [7:0] expected;
        bus_write(ppu_pkg::reg_ctrl0, step_bit);
        bus_write(ppu_pkg::reg_addr, 8'h24);
        bus_write(ppu_pkg::reg_addr, 8'h00);
        for (int k = 0; k < 9; k++) begin
            bus_read(ppu_pkg::reg_data, got);
            expected = (k == 0) ? rbuf_model : vram_model['h400 + (k - 1) * stride];
            if (got !== expected) report_mismatch(test, expected, got);
        end
        rbuf_model = vram_model['h400 + 8 * stride];
    endtask

    // step 32 fill overwrites only 0x2400 of the step 1 fill
    task automatic vram_data_port();
        data_port_fill(8'h00, 1, 8'h11);
        // control 0 bit 2 selects the +32 step
        data_port_fill(8'h04, 32, 8'h81);
        data_port_check("vram_data_port step 1", 8'h00, 1);
        data_port_check("vram_data_port step 32", 8'h04, 32);
        bus_write(ppu_pkg::reg_ctrl0, 8'h00);
    endtask

    task automatic vblank_status();
        logic [7:0] got;
        wait_vs_rise();
        bus_read(ppu_pkg::reg_status, got);
        if (got !== 8'h80) report_mismatch("vblank_status first read", 8'h80, got);
        bus_read(ppu_pkg::reg_status, got);
        if (got !== 8'h00) report_mismatch("vblank_status second read", 8'h00, got);
    endtask

    task automatic render_colour();
        bus_write(ppu_pkg::pal_base, 8'h01);
        pal_model[0] = 6'h01;
        bus_write(ppu_pkg::pal_base + 16'd3, 8'h30);
        pal_model[3] = 6'h30;
        capture_line(centre_y);
        if (line_rgb[centre_x] !== ppu_pkg::master_palette[pal_model[0]])
            report_mismatch("render_colour off", ppu_pkg::master_palette[pal_model[0]],
                            line_rgb[centre_x]);
        // tile 0 both planes solid, name and attribute bytes all zero
        bus_write(ppu_pkg::reg_addr, 8'h00);
        bus_write(ppu_pkg::reg_addr, 8'h00);
        for (int k = 0; k < 16; k++) bus_write(ppu_pkg::reg_data, 8'hFF);
        bus_write(ppu_pkg::reg_addr, 8'h20);
        bus_write(ppu_pkg::reg_addr, 8'h00);
        for (int k = 0; k < 1024; k++) bus_write(ppu_pkg::reg_data, 8'h00);
        bus_write(ppu_pkg::reg_ctrl1, 8'h08);
        capture_line(centre_y);
        if (line_rgb[centre_x] !== ppu_pkg::master_palette[pal_model[3]])
            report_mismatch("render_colour on", ppu_pkg::master_palette[pal_model[3]],
                            line_rgb[centre_x]);
        for (int i = 0; i < int'(ppu_pkg::win_left); i++) begin
            if (line_rgb[i] !== ppu_pkg::border_rgb)
                report_mismatch("render_colour border", ppu_pkg::border_rgb, line_rgb[i]);
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        ea         = '0;
        din        = '0;
        rd         = 1'b0;
        wreq       = 1'b0;
        rst        = 1'b1;
        errors     = 0;
        rbuf_model = '0;
        void'($urandom(75446));
        repeat (5) @(posedge CLK25);
        rst <= 1'b0;
        reset_state();
        sync_timing();
        palette_rw();
        vram_data_port();
        vblank_status();
        render_colour();
        assert_fails = UUT.u_props.hs_fails + UUT.u_props.bus_fails + UUT.u_props.blank_fails;
        $display("summary: %0d check errors, %0d assertion failures", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
rtl/ppu_pkg.sv
rtl/ppu_ram.sv
rtl/vga_timing.sv
rtl/ppu_regs.sv
rtl/bg_fetch.sv
rtl/video_out.sv
rtl/ppu_top.sv
sim/ppu_properties.sv
sim/tb_ppu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ppu
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell cat $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation ended without a verdict"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
